/* src/b32_macros.svh */
`ifndef B32_MACROS_SVH
`define B32_MACROS_SVH

// Data word and instruction width
`define B32_WORD_WIDTH 32

// Instruction address width
`define B32_PC_WIDTH 8

// Number of instruction words
`define B32_IMEM_DEPTH 256

// Register index width, 16 registers
`define B32_REG_ADDR_WIDTH 4

// PC after reset
`define B32_START_PC 0

`endif

/* src/b32_pkg.sv */
`include "b32_macros.svh"

package b32_pkg;

    typedef logic [`B32_WORD_WIDTH-1:0] word_t;

    // Wraps modulo the instruction memory size
    typedef logic [`B32_PC_WIDTH-1:0] pc_t;

    typedef logic [`B32_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Instruction bits 31..28, codes 5 and up behave as NOP
    typedef enum logic [3:0] {
        ARITH  = 4'd0,
        ARITHC = 4'd1,
        BRANCH = 4'd2,
        JUMP   = 4'd3,
        HALT   = 4'd4,
        NOP    = 4'd15
    } instr_class_e;

    // Codes 10 to 15 give a zero result
    typedef enum logic [3:0] {
        ALU_OR   = 4'd0,
        ALU_AND  = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_ADD  = 4'd3,
        ALU_SUB  = 4'd4,
        ALU_SHL  = 4'd5,
        ALU_SHR  = 4'd6,
        ALU_NOTA = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Codes 3 and 7 are never taken
    typedef enum logic [2:0] {
        BEQ = 3'd0,
        BGT = 3'd1,
        BGE = 3'd2,
        BNE = 3'd4,
        BLT = 3'd5,
        BLE = 3'd6
    } branch_op_e;

endpackage

/* src/b32_alu.sv */
module b32_alu (
    input  b32_pkg::alu_op_e   op,
    input  b32_pkg::word_t     a,
    input  b32_pkg::word_t     b,
    output b32_pkg::word_t     y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            b32_pkg::ALU_OR:   y = a | b;
            b32_pkg::ALU_AND:  y = a & b;
            b32_pkg::ALU_XOR:  y = a ^ b;
            b32_pkg::ALU_ADD:  y = a + b;
            b32_pkg::ALU_SUB:  y = a - b;
            b32_pkg::ALU_SHL:  y = a << shamt;
            // Logical shift, zeros come in from the top
            b32_pkg::ALU_SHR:  y = a >> shamt;
            b32_pkg::ALU_NOTA: y = ~a;
            b32_pkg::ALU_SLT:
            begin
                y = ($signed(a) < $signed(b)) ? b32_pkg::word_t'(1) : '0;
            end
            b32_pkg::ALU_SLTU:
            begin
                y = (a < b) ? b32_pkg::word_t'(1) : '0;
            end
            // Unassigned codes
            default: y = '0;
        endcase
    end

endmodule

/* src/b32_fetch.sv */
`include "b32_macros.svh"

module b32_fetch (
    input  logic             clk,
    input  logic             reset,
    input  logic             prog_we,
    input  b32_pkg::pc_t     prog_addr,
    input  b32_pkg::word_t   prog_data,
    input  logic             redirect,
    input  b32_pkg::pc_t     redirect_pc,
    output b32_pkg::word_t   instr_de,
    output b32_pkg::pc_t     pc_de
);

    // Class field set to NOP, all other bits zero
    localparam b32_pkg::word_t nop_instr = {b32_pkg::NOP, {(`B32_WORD_WIDTH-4){1'b0}}};

    b32_pkg::word_t imem [0:`B32_IMEM_DEPTH-1];
    b32_pkg::pc_t   pc;

    // Program load port
    always_ff @(posedge clk)
    begin
        if (prog_we)
        begin
            imem[prog_addr] <= prog_data;
        end
    end

    // PC and the FE to DE register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc       <= b32_pkg::pc_t'(`B32_START_PC);
            instr_de <= nop_instr;
            pc_de    <= '0;
        end
        else if (redirect)
        begin
            // Fetched word is on the wrong path, drop it
            pc       <= redirect_pc;
            instr_de <= nop_instr;
            pc_de    <= redirect_pc;
        end
        else
        begin
            pc       <= pc + b32_pkg::pc_t'(1);
            instr_de <= imem[pc];
            pc_de    <= pc;
        end
    end

endmodule

/* src/b32_decode.sv */
module b32_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  b32_pkg::word_t          instr_de,
    input  b32_pkg::pc_t            pc_de,
    input  logic                    flush,
    output b32_pkg::reg_addr_t      areg_de,
    output b32_pkg::reg_addr_t      breg_de,
    output b32_pkg::instr_class_e   class_ex,
    output b32_pkg::alu_op_e        alu_op_ex,
    output b32_pkg::branch_op_e     branch_op_ex,
    output logic                    signed_ex,
    output logic                    relative_ex,
    output b32_pkg::word_t          imm_ex,
    output b32_pkg::reg_addr_t      areg_ex,
    output b32_pkg::reg_addr_t      breg_ex,
    output b32_pkg::reg_addr_t      dreg_ex,
    output b32_pkg::pc_t            pc_ex
);

    b32_pkg::instr_class_e cls;
    b32_pkg::word_t        imm;
    b32_pkg::reg_addr_t    dreg;

    always_comb
    begin
        cls     = (instr_de[31:28] > 4'd4) ? b32_pkg::NOP
                                           : b32_pkg::instr_class_e'(instr_de[31:28]);
        areg_de = '0;
        breg_de = '0;
        dreg    = '0;
        imm     = '0;
        case (cls)
            b32_pkg::ARITH:
            begin
                areg_de = instr_de[11:8];
                breg_de = instr_de[7:4];
                dreg    = instr_de[3:0];
            end
            b32_pkg::ARITHC:
            begin
                imm     = {{16{instr_de[23]}}, instr_de[23:8]};
                areg_de = instr_de[7:4];
                dreg    = instr_de[3:0];
            end
            b32_pkg::BRANCH:
            begin
                imm     = {{16{instr_de[27]}}, instr_de[27:12]};
                areg_de = instr_de[11:8];
                breg_de = instr_de[7:4];
            end
            // Only the low PC bits of the target matter
            b32_pkg::JUMP: imm = {5'd0, instr_de[26:0]};
            default: imm = '0;
        endcase
    end

    // DE to EX register, flush inserts a bubble
    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            class_ex     <= reset ? b32_pkg::ARITH : b32_pkg::NOP;
            alu_op_ex    <= b32_pkg::ALU_OR;
            branch_op_ex <= b32_pkg::BEQ;
            signed_ex    <= 1'b0;
            relative_ex  <= 1'b0;
            imm_ex       <= '0;
            areg_ex      <= '0;
            breg_ex      <= '0;
            dreg_ex      <= '0;
            pc_ex        <= '0;
        end
        else
        begin
            class_ex     <= cls;
            alu_op_ex    <= b32_pkg::alu_op_e'(instr_de[27:24]);
            branch_op_ex <= b32_pkg::branch_op_e'(instr_de[3:1]);
            signed_ex    <= instr_de[0];
            relative_ex  <= instr_de[27];
            imm_ex       <= imm;
            areg_ex      <= areg_de;
            breg_ex      <= breg_de;
            dreg_ex      <= dreg;
            pc_ex        <= pc_de;
        end
    end

endmodule

/* src/b32_regbank.sv */
module b32_regbank (
    input  logic                 clk,
    input  logic                 reset,
    input  b32_pkg::reg_addr_t   addr_a,
    input  b32_pkg::reg_addr_t   addr_b,
    output b32_pkg::word_t       data_a,
    output b32_pkg::word_t       data_b,
    input  logic                 we,
    input  b32_pkg::reg_addr_t   addr_d,
    input  b32_pkg::word_t       data_d
);

    b32_pkg::word_t regs [1:15];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < 16; i++)
            begin
                regs[i] <= '0;
            end
            data_a <= '0;
            data_b <= '0;
        end
        else
        begin
            if (we && addr_d != '0)
            begin
                regs[addr_d] <= data_d;
            end

            // Register 0 reads as zero, a same-cycle write passes straight through
            if (addr_a == '0)
                data_a <= '0;
            else if (we && addr_d == addr_a)
                data_a <= data_d;
            else
                data_a <= regs[addr_a];

            if (addr_b == '0)
                data_b <= '0;
            else if (we && addr_d == addr_b)
                data_b <= data_d;
            else
                data_b <= regs[addr_b];
        end
    end

endmodule

/* src/b32_execute.sv */
module b32_execute (
    input  logic                    clk,
    input  logic                    reset,
    input  b32_pkg::instr_class_e   class_ex,
    input  b32_pkg::alu_op_e        alu_op_ex,
    input  b32_pkg::branch_op_e     branch_op_ex,
    input  logic                    signed_ex,
    input  logic                    relative_ex,
    input  b32_pkg::word_t          imm_ex,
    input  b32_pkg::reg_addr_t      areg_ex,
    input  b32_pkg::reg_addr_t      breg_ex,
    input  b32_pkg::reg_addr_t      dreg_ex,
    input  b32_pkg::pc_t            pc_ex,
    input  b32_pkg::word_t          data_a,
    input  b32_pkg::word_t          data_b,
    output logic                    redirect,
    output b32_pkg::pc_t            redirect_pc,
    output logic                    wb_valid,
    output b32_pkg::reg_addr_t      wb_reg,
    output b32_pkg::word_t          wb_data,
    output logic                    halted
);

    b32_pkg::word_t op_a;
    b32_pkg::word_t op_b;
    b32_pkg::word_t alu_b;
    b32_pkg::word_t alu_y;
    logic           taken;
    logic           is_alu;

    // WB result forwarded when EX reads the register being written
    assign op_a = (wb_valid && wb_reg == areg_ex && areg_ex != '0) ? wb_data : data_a;
    assign op_b = (wb_valid && wb_reg == breg_ex && breg_ex != '0) ? wb_data : data_b;

    assign alu_b  = (class_ex == b32_pkg::ARITHC) ? imm_ex : op_b;
    assign is_alu = (class_ex == b32_pkg::ARITH) || (class_ex == b32_pkg::ARITHC);

    b32_alu u_alu (
        .op (alu_op_ex),
        .a  (op_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_comb
    begin
        case (branch_op_ex)
            b32_pkg::BEQ: taken = (op_a == op_b);
            b32_pkg::BNE: taken = (op_a != op_b);
            b32_pkg::BGT: taken = signed_ex ? ($signed(op_a) > $signed(op_b)) : (op_a > op_b);
            b32_pkg::BGE: taken = signed_ex ? ($signed(op_a) >= $signed(op_b)) : (op_a >= op_b);
            b32_pkg::BLT: taken = signed_ex ? ($signed(op_a) < $signed(op_b)) : (op_a < op_b);
            b32_pkg::BLE: taken = signed_ex ? ($signed(op_a) <= $signed(op_b)) : (op_a <= op_b);
            default: taken = 1'b0;
        endcase
    end

    // Redirect target, halt keeps jumping to itself
    always_comb
    begin
        redirect    = 1'b0;
        redirect_pc = pc_ex;
        case (class_ex)
            b32_pkg::BRANCH:
            begin
                redirect    = taken;
                redirect_pc = pc_ex + b32_pkg::pc_t'(imm_ex);
            end
            b32_pkg::JUMP:
            begin
                redirect    = 1'b1;
                redirect_pc = relative_ex ? pc_ex + b32_pkg::pc_t'(imm_ex)
                                          : b32_pkg::pc_t'(imm_ex);
            end
            b32_pkg::HALT: redirect = 1'b1;
            default: redirect = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_valid <= 1'b0;
            wb_reg   <= '0;
            wb_data  <= '0;
            halted   <= 1'b0;
        end
        else
        begin
            // Writes to register 0 are dropped here
            wb_valid <= is_alu && (dreg_ex != '0);
            wb_reg   <= dreg_ex;
            wb_data  <= alu_y;
            if (class_ex == b32_pkg::HALT)
                halted <= 1'b1;
        end
    end

endmodule

/* src/b32_cpu.sv */
module b32_cpu (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 prog_we,
    input  b32_pkg::pc_t         prog_addr,
    input  b32_pkg::word_t       prog_data,
    output logic                 wb_valid,
    output b32_pkg::reg_addr_t   wb_reg,
    output b32_pkg::word_t       wb_data,
    output logic                 halted
);

    // FE to DE
    b32_pkg::word_t        instr_de;
    b32_pkg::pc_t          pc_de;

    // DE to register bank
    b32_pkg::reg_addr_t    areg_de;
    b32_pkg::reg_addr_t    breg_de;

    // DE to EX
    b32_pkg::instr_class_e class_ex;
    b32_pkg::alu_op_e      alu_op_ex;
    b32_pkg::branch_op_e   branch_op_ex;
    logic                  signed_ex;
    logic                  relative_ex;
    b32_pkg::word_t        imm_ex;
    b32_pkg::reg_addr_t    areg_ex;
    b32_pkg::reg_addr_t    breg_ex;
    b32_pkg::reg_addr_t    dreg_ex;
    b32_pkg::pc_t          pc_ex;
    b32_pkg::word_t        data_a;
    b32_pkg::word_t        data_b;

    // EX back to FE and DE
    logic                  redirect;
    b32_pkg::pc_t          redirect_pc;

    b32_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_de    (instr_de),
        .pc_de       (pc_de)
    );

    b32_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .instr_de     (instr_de),
        .pc_de        (pc_de),
        .flush        (redirect),
        .areg_de      (areg_de),
        .breg_de      (breg_de),
        .class_ex     (class_ex),
        .alu_op_ex    (alu_op_ex),
        .branch_op_ex (branch_op_ex),
        .signed_ex    (signed_ex),
        .relative_ex  (relative_ex),
        .imm_ex       (imm_ex),
        .areg_ex      (areg_ex),
        .breg_ex      (breg_ex),
        .dreg_ex      (dreg_ex),
        .pc_ex        (pc_ex)
    );

    b32_regbank u_regbank (
        .clk    (clk),
        .reset  (reset),
        .addr_a (areg_de),
        .addr_b (breg_de),
        .data_a (data_a),
        .data_b (data_b),
        .we     (wb_valid),
        .addr_d (wb_reg),
        .data_d (wb_data)
    );

    b32_execute u_execute (
        .clk          (clk),
        .reset        (reset),
        .class_ex     (class_ex),
        .alu_op_ex    (alu_op_ex),
        .branch_op_ex (branch_op_ex),
        .signed_ex    (signed_ex),
        .relative_ex  (relative_ex),
        .imm_ex       (imm_ex),
        .areg_ex      (areg_ex),
        .breg_ex      (breg_ex),
        .dreg_ex      (dreg_ex),
        .pc_ex        (pc_ex),
        .data_a       (data_a),
        .data_b       (data_b),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .halted       (halted)
    );

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk
);

    // Period of 10 time units
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

endmodule

/* tb/b32_asserts.sv */
module b32_asserts (
    input logic               clk,
    input logic               reset,
    input logic               wb_valid,
    input b32_pkg::reg_addr_t wb_reg,
    input logic               halted
);

    // Register 0 is never reported
    a_no_wb_r0: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_reg != '0)
        else $error("writeback reported for register 0");

    // Nothing retires once the core has halted
    a_no_wb_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !wb_valid)
        else $error("writeback reported while halted");

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !wb_valid && !halted)
        else $error("wb_valid or halted high in the cycle after reset");

endmodule

bind b32_cpu b32_asserts u_b32_asserts (
    .clk      (clk),
    .reset    (reset),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .halted   (halted)
);

/* tb/tb_b32.sv */
`include "b32_macros.svh"

module tb_b32;

    localparam int PROG_LEN   = 60;
    localparam int LOAD_LEN   = 64;
    localparam int MAX_CYCLES = 4 * PROG_LEN + 50;

    logic               clk;
    logic               reset;
    logic               prog_we;
    b32_pkg::pc_t       prog_addr;
    b32_pkg::word_t     prog_data;
    logic               wb_valid;
    b32_pkg::reg_addr_t wb_reg;
    b32_pkg::word_t     wb_data;
    logic               halted;

    b32_pkg::word_t     prog [0:LOAD_LEN-1];
    b32_pkg::reg_addr_t exp_reg_q [$];
    b32_pkg::word_t     exp_data_q [$];
    b32_pkg::reg_addr_t recent [0:1];
    integer             seed;
    int                 wb_errors;
    int                 count_errors;
    int                 flag_errors;
    int                 other_errors;
    int                 n_reports;
    int                 cycles;
    int                 exp_halt_cycles;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    b32_cpu u_b32_cpu (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    // Half the picks reuse one of the last two destinations
    function automatic b32_pkg::reg_addr_t pick_reg();
        logic sel;
        sel = 1'($random(seed));
        if (sel)
            return recent[1'($random(seed))];
        return b32_pkg::reg_addr_t'($random(seed));
    endfunction

    function automatic b32_pkg::word_t alu_model(input logic [3:0] op, input b32_pkg::word_t a,
                                                 input b32_pkg::word_t b);
        case (op)
            4'd0: return a | b;
            4'd1: return a & b;
            4'd2: return a ^ b;
            4'd3: return a + b;
            4'd4: return a - b;
            4'd5: return a << b[4:0];
            4'd6: return a >> b[4:0];
            4'd7: return ~a;
            4'd8: return {31'd0, $signed(a) < $signed(b)};
            4'd9: return {31'd0, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] cond, input logic sgn,
                                          input b32_pkg::word_t a, input b32_pkg::word_t b);
        logic eq;
        logic lt;
        eq = (a == b);
        lt = sgn ? ($signed(a) < $signed(b)) : (a < b);
        case (cond)
            3'd0: return eq;
            3'd1: return !lt && !eq;
            3'd2: return !lt;
            3'd4: return !eq;
            3'd5: return lt;
            3'd6: return lt || eq;
            default: return 1'b0;
        endcase
    endfunction

    task automatic gen_program();
        int                 kind;
        int                 off;
        logic [3:0]         op;
        b32_pkg::reg_addr_t a;
        b32_pkg::reg_addr_t b;
        b32_pkg::reg_addr_t d;
        recent[0] = 4'd1;
        recent[1] = 4'd2;
        for (int pc = 0; pc < LOAD_LEN; pc++)
        begin
            op   = 4'($random(seed));
            a    = pick_reg();
            b    = pick_reg();
            d    = pick_reg();
            kind = {$random(seed)} % 20;
            off  = 1 + {$random(seed)} % 4;
            // Targets stay forward and inside the program
            if (pc + off > PROG_LEN - 1)
                off = PROG_LEN - 1 - pc;
            // Seed four registers, then sweep every ALU code plus one unused
            if (pc < 4)
            begin
                op   = 4'd3;
                d    = b32_pkg::reg_addr_t'(pc + 1);
                kind = 9;
            end
            else if (pc < 15)
            begin
                op   = 4'(pc - 4);
                kind = 0;
                // Writes to register 0 are never reported
                if (d == '0)
                    d = 4'd1;
            end
            if (pc >= PROG_LEN)
                prog[pc] = {4'd15, 28'd0};
            else if (pc == PROG_LEN - 1)
                prog[pc] = {4'd4, 28'd0};
            else if (kind < 9)
                prog[pc] = {4'd0, op, 12'($random(seed)), a, b, d};
            else if (kind < 13)
                prog[pc] = {4'd1, op, 16'($random(seed)), a, d};
            else if (kind < 16)
                prog[pc] = {4'd2, 16'(off), a, b, 3'($random(seed)), 1'($random(seed))};
            else if (kind == 16)
                prog[pc] = {4'd3, 1'b0, 19'($random(seed)), 8'(pc + off)};
            else if (kind == 17)
                prog[pc] = {4'd3, 1'b1, 19'($random(seed)), 8'(off)};
            else
                prog[pc] = {4'(5 + {$random(seed)} % 11), 28'($random(seed))};
            if (kind < 13)
            begin
                recent[1] = recent[0];
                recent[0] = d;
            end
        end
    endtask

    // Sequential walk of the program, one instruction at a time
    task automatic run_model();
        b32_pkg::word_t regs [0:15];
        b32_pkg::word_t w;
        b32_pkg::word_t res;
        b32_pkg::pc_t   pc;
        logic           wr;
        int             steps;
        int             redirects;
        for (int i = 0; i < 16; i++)
        begin
            regs[i] = '0;
        end
        pc        = b32_pkg::pc_t'(`B32_START_PC);
        steps     = 0;
        redirects = 0;
        while (prog[pc][31:28] != 4'd4 && steps < 1000)
        begin
            w  = prog[pc];
            wr = 1'b0;
            pc = pc + 8'd1;
            case (w[31:28])
                4'd0:
                begin
                    res = alu_model(w[27:24], regs[w[11:8]], regs[w[7:4]]);
                    wr  = 1'b1;
                end
                4'd1:
                begin
                    res = alu_model(w[27:24], regs[w[7:4]], {{16{w[23]}}, w[23:8]});
                    wr  = 1'b1;
                end
                4'd2:
                begin
                    if (branch_model(w[3:1], w[0], regs[w[11:8]], regs[w[7:4]]))
                    begin
                        pc = pc - 8'd1 + w[19:12];
                        redirects++;
                    end
                end
                4'd3:
                begin
                    pc = w[27] ? pc - 8'd1 + w[7:0] : w[7:0];
                    redirects++;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[3:0] != 4'd0)
            begin
                regs[w[3:0]] = res;
                exp_reg_q.push_back(w[3:0]);
                exp_data_q.push_back(res);
            end
            steps++;
        end
        // HALT leaves EX three edges after reset release plus one per instruction ahead,
        // each redirect costs two more, and the flag is seen at the next falling edge
        exp_halt_cycles = 4 + steps + 2 * redirects;
    endtask

    task automatic check_wb(input string name, input b32_pkg::reg_addr_t exp_reg,
                            input b32_pkg::word_t exp_data, input b32_pkg::reg_addr_t act_reg,
                            input b32_pkg::word_t act_data);
        if (act_reg !== exp_reg || act_data !== exp_data)
        begin
            wb_errors++;
            $display("ERROR %s: expected r%0d = %h, actual r%0d = %h",
                     name, exp_reg, exp_data, act_reg, act_data);
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (exp_n != act_n)
        begin
            count_errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp_n, act_n);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
        begin
            flag_errors++;
            $display("ERROR %s: expected %0b, actual %0b", name, exp_val, act_val);
        end
    endtask

    task automatic take_report();
        if (wb_valid)
        begin
            n_reports++;
            if (exp_reg_q.size() == 0)
            begin
                other_errors++;
                $display("Writeback to r%0d reported when none was expected", wb_reg);
            end
            else
            begin
                check_wb($sformatf("writeback %0d", n_reports), exp_reg_q.pop_front(),
                         exp_data_q.pop_front(), wb_reg, wb_data);
            end
        end
    endtask

    initial
    begin
        reset        = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        seed         = 56;
        wb_errors    = 0;
        count_errors = 0;
        flag_errors  = 0;
        other_errors = 0;
        n_reports    = 0;
        gen_program();
        run_model();

        // Program load under reset
        for (int i = 0; i < LOAD_LEN; i++)
        begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= b32_pkg::pc_t'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (!halted && cycles < MAX_CYCLES)
        begin
            @(negedge clk);
            take_report();
            cycles++;
        end

        if (!halted)
        begin
            other_errors++;
            $display("Timeout: halted did not rise within %0d cycles", MAX_CYCLES);
        end
        else
        begin
            check_count("pending writebacks at halt", 0, exp_reg_q.size());
            check_count("cycles until halted", exp_halt_cycles, cycles);
            // Watch a while longer for stray reports
            repeat (10)
            begin
                @(negedge clk);
                take_report();
                check_flag("halted stays high", 1'b1, halted);
            end
        end

        $display("Errors: writeback %0d, count %0d, halted %0d, other %0d",
                 wb_errors, count_errors, flag_errors, other_errors);
        if (wb_errors == 0 && count_errors == 0 && flag_errors == 0 && other_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* b32.f */
+incdir+src
src/b32_pkg.sv
src/b32_alu.sv
src/b32_fetch.sv
src/b32_decode.sv
src/b32_regbank.sv
src/b32_execute.sv
src/b32_cpu.sv
tb/tb_clock_gen.sv
tb/b32_asserts.sv
tb/tb_b32.sv

/* run.sh */
#!/bin/sh
# Build and run the B32 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_b32 -f b32.f

result=$(./obj_dir/Vtb_b32 2>&1) || true
echo "$result"

if echo "$result" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
exit 1
